/* src.f */
+incdir+common
common/tile_pkg.sv
bank/tcdm_bank.sv
xbar/bank_xbar.sv
router/addr_router.sv
verilog/tcdm_tile.sv
tests/tcdm_tile_assertions.sv
tests/tcdm_tile_tb.sv

/* Makefile */
TOP := tcdm_tile_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): src.f common/tile_consts.svh common/tile_pkg.sv bank/tcdm_bank.sv \
                 xbar/bank_xbar.sv router/addr_router.sv verilog/tcdm_tile.sv \
                 tests/tcdm_tile_assertions.sv tests/tcdm_tile_tb.sv
	verilator --binary --timing --assert -f src.f --top-module $(TOP)

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* tests/tcdm_tile_tb.sv */
`timescale 1ns/100ps
`include "tile_consts.svh"

module tcdm_tile_tb;

  localparam int timeout_cycles = 64;

  logic                       clk;
  logic                       rst_n;
  logic [1:0]                 tile_id;
  tile_pkg::tcdm_req_t  [1:0] core_req;
  logic                 [1:0] core_req_valid;
  logic                 [1:0] core_req_ready;
  tile_pkg::tcdm_resp_t [1:0] core_resp;
  logic                 [1:0] core_resp_valid;
  tile_pkg::tcdm_req_t        remote_req;
  logic                       remote_req_valid;
  logic                       remote_req_ready;
  tile_pkg::tcdm_resp_t       remote_resp;
  logic                       remote_resp_valid;
  tile_pkg::slave_req_t [1:0] slave_req;
  logic                 [1:0] slave_req_valid;
  logic                 [1:0] slave_req_ready;
  tile_pkg::tcdm_resp_t [1:0] slave_resp;
  logic                 [1:0] slave_resp_valid;

  logic [31:0] lfsr_q = 32'h2a69_c8d3;
  logic [31:0] ref_mem [1024];
  string       cur_test;
  int          errors;
  int          test_errs;
  int          tests_run;
  int          tests_bad;

  tcdm_tile tcdm_tile_inst (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .tile_id_i           (tile_id),
    .core_req_i          (core_req),
    .core_req_valid_i    (core_req_valid),
    .core_req_ready_o    (core_req_ready),
    .core_resp_o         (core_resp),
    .core_resp_valid_o   (core_resp_valid),
    .remote_req_o        (remote_req),
    .remote_req_valid_o  (remote_req_valid),
    .remote_req_ready_i  (remote_req_ready),
    .remote_resp_i       (remote_resp),
    .remote_resp_valid_i (remote_resp_valid),
    .slave_req_i         (slave_req),
    .slave_req_valid_i   (slave_req_valid),
    .slave_req_ready_o   (slave_req_ready),
    .slave_resp_o        (slave_resp),
    .slave_resp_valid_o  (slave_resp_valid)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [31:0] tcdm_addr(input logic [7:0] word, input logic [1:0] tile,
                                            input logic [1:0] bank);
    return `TILE_TCDM_BASE + {18'd0, word, tile, bank, 2'b00};
  endfunction

  // Reference memory indexed by {word, bank}
  task automatic ref_write(input logic [9:0] idx, input logic [31:0] data,
                           input logic [3:0] mask);
    for (int i = 0; i < 4; i++) begin
      if (mask[i]) begin
        ref_mem[idx][8*i +: 8] = data[8*i +: 8];
      end
    end
  endtask

  task automatic check_eq(input string name, input logic [32:0] exp, input logic [32:0] got);
    assert (got === exp) else begin
      $display("MISMATCH %s %s expected %h actual %h", cur_test, name, exp, got);
      errors++;
      test_errs++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("ERROR %s %s", cur_test, msg);
    errors++;
    test_errs++;
  endtask

  task automatic finish_test();
    tests_run++;
    if (test_errs == 0) begin
      $display("PASS %s", cur_test);
    end else begin
      tests_bad++;
      $display("FAIL %s with %0d errors", cur_test, test_errs);
    end
    test_errs = 0;
  endtask

  task automatic core_access(input int c, input logic [31:0] address, input logic write,
                             input logic [31:0] data, input logic [3:0] mask,
                             output tile_pkg::tcdm_resp_t resp);
    int n;
    @(posedge clk);
    core_req[c]       <= '{addr: address, wen: write, wdata: data, be: mask};
    core_req_valid[c] <= 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!core_req_ready[c] && n < timeout_cycles);
    if (!core_req_ready[c]) report_failure($sformatf("core %0d request never accepted", c));
    @(posedge clk);
    core_req_valid[c] <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!core_resp_valid[c] && n < timeout_cycles);
    if (!core_resp_valid[c]) report_failure($sformatf("core %0d got no response", c));
    resp = core_resp[c];
  endtask

  task automatic slave_access(input int s, input logic [9:0] address, input logic write,
                              input logic [31:0] data, input logic [3:0] mask,
                              output tile_pkg::tcdm_resp_t resp);
    int n;
    @(posedge clk);
    slave_req[s]       <= '{addr: address, wen: write, wdata: data, be: mask};
    slave_req_valid[s] <= 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!slave_req_ready[s] && n < timeout_cycles);
    if (!slave_req_ready[s]) report_failure($sformatf("slave %0d request never accepted", s));
    @(posedge clk);
    slave_req_valid[s] <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!slave_resp_valid[s] && n < timeout_cycles);
    if (!slave_resp_valid[s]) report_failure($sformatf("slave %0d got no response", s));
    resp = slave_resp[s];
  endtask

  // Models the other tile, stalls ready and the answer by random cycles
  task automatic serve_remote(input tile_pkg::tcdm_req_t exp, input logic [31:0] data);
    int n;
    int delay;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!remote_req_valid && n < timeout_cycles);
    if (!remote_req_valid) begin
      report_failure("no remote request issued");
      return;
    end
    check_eq("remote address", {1'b0, exp.addr}, {1'b0, remote_req.addr});
    check_eq("remote write data", {1'b0, exp.wdata}, {1'b0, remote_req.wdata});
    check_eq("remote wen and be", {28'd0, exp.wen, exp.be},
             {28'd0, remote_req.wen, remote_req.be});
    delay = int'(rand_bits(3));
    repeat (delay) @(posedge clk);
    @(posedge clk);
    remote_req_ready <= 1'b1;
    @(posedge clk);
    remote_req_ready <= 1'b0;
    delay = int'(rand_bits(3));
    repeat (delay) @(posedge clk);
    @(posedge clk);
    remote_resp       <= '{rdata: data, err: 1'b0};
    remote_resp_valid <= 1'b1;
    @(posedge clk);
    remote_resp_valid <= 1'b0;
  endtask

  initial begin
    tile_pkg::tcdm_resp_t resp;
    tile_pkg::tcdm_resp_t rsp [3];
    tile_pkg::tcdm_req_t  rq;
    logic [31:0]          cdata [3];
    logic [7:0]           w;
    logic [1:0]           b;
    logic [31:0]          a;
    logic [31:0]          d;
    logic [31:0]          rd;
    logic [3:0]           m;

    rst_n             <= 1'b0;
    tile_id           <= 2'd1;
    core_req          <= '0;
    core_req_valid    <= '0;
    remote_req_ready  <= 1'b0;
    remote_resp       <= '0;
    remote_resp_valid <= 1'b0;
    slave_req         <= '0;
    slave_req_valid   <= '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    cur_test = "reset";
    @(negedge clk);
    check_eq("valids low", 33'd0, {28'd0, core_resp_valid, slave_resp_valid, remote_req_valid});
    @(negedge clk);
    check_eq("core ready", 33'd3, {31'd0, core_req_ready});
    finish_test();

    cur_test = "local access";
    w = 8'(rand_bits(8));
    b = 2'(rand_bits(2));
    a = tcdm_addr(w, 2'd1, b);
    d = rand_bits(32);
    core_access(0, a, 1'b1, d, 4'hf, resp);
    ref_write({w, b}, d, 4'hf);
    check_eq("write ack", 33'd0, resp);
    d = rand_bits(32);
    m = 4'(rand_bits(4));
    core_access(0, a, 1'b1, d, m, resp);
    ref_write({w, b}, d, m);
    core_access(0, a, 1'b0, 32'd0, 4'hf, resp);
    check_eq("read merge", {ref_mem[{w, b}], 1'b0}, resp);
    finish_test();

    // Core 0 reads and core 1 writes, a remote write is answered with zero data
    cur_test = "remote access";
    for (int c = 0; c < 2; c++) begin
      w  = 8'(rand_bits(8));
      b  = 2'(rand_bits(2));
      d  = rand_bits(32);
      m  = 4'(rand_bits(4));
      rd = c ? 32'd0 : rand_bits(32);
      rq = '{addr: {17'd0, w, b, 2'd3, 1'(c), 2'b00}, wen: 1'(c), wdata: d, be: m};
      fork
        core_access(c, tcdm_addr(w, 2'd3, b), 1'(c), d, m, resp);
        serve_remote(rq, rd);
      join
      check_eq("remote response", {rd, 1'b0}, resp);
    end
    finish_test();

    cur_test = "error access";
    core_access(0, 32'h0000_4000, 1'b0, 32'd0, 4'hf, resp);
    check_eq("below region", 33'h1, resp);
    core_access(1, `TILE_TCDM_BASE + 32'h4000, 1'b1, 32'hffff_ffff, 4'hf, resp);
    check_eq("above region", 33'h1, resp);
    finish_test();

    // Three initiators on bank 3 in the same cycle, distinct words
    cur_test = "contention";
    for (int k = 0; k < 3; k++) begin
      cdata[k] = rand_bits(32);
      ref_write({8'(20 + k), 2'd3}, cdata[k], 4'hf);
    end
    fork
      core_access(0, tcdm_addr(8'd20, 2'd1, 2'd3), 1'b1, cdata[0], 4'hf, rsp[0]);
      core_access(1, tcdm_addr(8'd21, 2'd1, 2'd3), 1'b1, cdata[1], 4'hf, rsp[1]);
      slave_access(0, {8'd22, 2'd3}, 1'b1, cdata[2], 4'hf, rsp[2]);
    join
    core_access(0, tcdm_addr(8'd21, 2'd1, 2'd3), 1'b0, 32'd0, 4'hf, rsp[0]);
    core_access(1, tcdm_addr(8'd22, 2'd1, 2'd3), 1'b0, 32'd0, 4'hf, rsp[1]);
    slave_access(1, {8'd20, 2'd3}, 1'b0, 32'd0, 4'hf, rsp[2]);
    check_eq("core 0 read", {ref_mem[{8'd21, 2'd3}], 1'b0}, rsp[0]);
    check_eq("core 1 read", {ref_mem[{8'd22, 2'd3}], 1'b0}, rsp[1]);
    check_eq("slave 1 read", {ref_mem[{8'd20, 2'd3}], 1'b0}, rsp[2]);
    finish_test();

    $display("%0d tests run, %0d with errors, %0d errors in total", tests_run, tests_bad, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* tests/tcdm_tile_assertions.sv */
`timescale 1ns/100ps
`include "tile_consts.svh"

module tcdm_tile_assertions (
  input logic                                      clk_i,
  input logic                                      rst_ni,
  input logic                [`TILE_NUM_CORES-1:0] core_req_valid_i,
  input logic                [`TILE_NUM_CORES-1:0] core_req_ready_o,
  input logic                [`TILE_NUM_CORES-1:0] core_resp_valid_o,
  input tile_pkg::tcdm_req_t                       remote_req_o,
  input logic                                      remote_req_valid_o,
  input logic                                      remote_req_ready_i,
  input logic                [`TILE_NUM_CORES-1:0] slave_req_valid_i,
  input logic                [`TILE_NUM_CORES-1:0] slave_req_ready_o,
  input logic                [`TILE_NUM_CORES-1:0] slave_resp_valid_o
);

  logic [`TILE_NUM_CORES-1:0] core_acc;
  logic [`TILE_NUM_CORES-1:0] pending_q;

  assign core_acc = core_req_valid_i & core_req_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= '0;
    end else begin
      pending_q <= (pending_q & ~core_resp_valid_o) | core_acc;
    end
  end

  for (genvar c = 0; c < `TILE_NUM_CORES; c++) begin : gen_core
    logic remote_acc;

    // Core index sits just above the byte offset in a remote address
    assign remote_acc = remote_req_valid_o && remote_req_ready_i &&
                        remote_req_o.addr[`TILE_BYTE_OFF] == 1'(c);

    a_fixed_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
      core_acc[c] && !remote_acc |=> core_resp_valid_o[c])
      else $error("core %0d local or error response not one cycle after acceptance", c);

    a_resp_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
      core_resp_valid_o[c] |-> pending_q[c])
      else $error("core %0d response without an outstanding request", c);

    a_slave_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
      slave_req_valid_i[c] && slave_req_ready_o[c] |=> slave_resp_valid_o[c])
      else $error("slave %0d response not one cycle after acceptance", c);
  end

  a_remote_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    remote_req_valid_o && !remote_req_ready_i |=> remote_req_valid_o && $stable(remote_req_o))
    else $error("remote request dropped or changed before ready");

  // Outputs idle while reset is held
  a_reset_idle: assert property (@(posedge clk_i)
    !rst_ni |-> core_resp_valid_o == '0 && core_req_ready_o == '0 &&
                !remote_req_valid_o && slave_resp_valid_o == '0)
    else $error("outputs active during reset");

endmodule

bind tcdm_tile tcdm_tile_assertions tcdm_tile_assertions_inst (
  .clk_i              (clk_i),
  .rst_ni             (rst_ni),
  .core_req_valid_i   (core_req_valid_i),
  .core_req_ready_o   (core_req_ready_o),
  .core_resp_valid_o  (core_resp_valid_o),
  .remote_req_o       (remote_req_o),
  .remote_req_valid_o (remote_req_valid_o),
  .remote_req_ready_i (remote_req_ready_i),
  .slave_req_valid_i  (slave_req_valid_i),
  .slave_req_ready_o  (slave_req_ready_o),
  .slave_resp_valid_o (slave_resp_valid_o)
);

/* verilog/tcdm_tile.sv */
`timescale 1ns/100ps
`include "tile_consts.svh"

module tcdm_tile (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic [`TILE_TILE_W-1:0]                    tile_id_i,
  // Core ports
  input  tile_pkg::tcdm_req_t  [`TILE_NUM_CORES-1:0] core_req_i,
  input  logic                 [`TILE_NUM_CORES-1:0] core_req_valid_i,
  output logic                 [`TILE_NUM_CORES-1:0] core_req_ready_o,
  output tile_pkg::tcdm_resp_t [`TILE_NUM_CORES-1:0] core_resp_o,
  output logic                 [`TILE_NUM_CORES-1:0] core_resp_valid_o,
  // Master port towards other tiles
  output tile_pkg::tcdm_req_t                        remote_req_o,
  output logic                                       remote_req_valid_o,
  input  logic                                       remote_req_ready_i,
  input  tile_pkg::tcdm_resp_t                       remote_resp_i,
  input  logic                                       remote_resp_valid_i,
  // Slave ports from other tiles
  input  tile_pkg::slave_req_t [`TILE_NUM_CORES-1:0] slave_req_i,
  input  logic                 [`TILE_NUM_CORES-1:0] slave_req_valid_i,
  output logic                 [`TILE_NUM_CORES-1:0] slave_req_ready_o,
  output tile_pkg::tcdm_resp_t [`TILE_NUM_CORES-1:0] slave_resp_o,
  output logic                 [`TILE_NUM_CORES-1:0] slave_resp_valid_o
);

  tile_pkg::bank_req_t  [`TILE_NUM_CORES-1:0] local_req;
  logic                 [`TILE_NUM_CORES-1:0] local_req_valid;
  logic                 [`TILE_NUM_CORES-1:0] local_req_ready;
  tile_pkg::tcdm_resp_t [`TILE_NUM_CORES-1:0] local_resp;
  logic                 [`TILE_NUM_CORES-1:0] local_resp_valid;
  tile_pkg::bank_req_t  [`TILE_NUM_CORES-1:0] slave_bank_req;

  tile_pkg::bank_req_t  [`TILE_NUM_INI-1:0]   ini_req;
  logic                 [`TILE_NUM_INI-1:0]   ini_req_valid;
  logic                 [`TILE_NUM_INI-1:0]   ini_req_ready;
  tile_pkg::tcdm_resp_t [`TILE_NUM_INI-1:0]   ini_resp;
  logic                 [`TILE_NUM_INI-1:0]   ini_resp_valid;

  tile_pkg::bank_req_t  [`TILE_NUM_BANKS-1:0] bank_req;
  logic                 [`TILE_NUM_BANKS-1:0] bank_req_valid;
  tile_pkg::bank_resp_t [`TILE_NUM_BANKS-1:0] bank_resp;
  logic                 [`TILE_NUM_BANKS-1:0] bank_resp_valid;

  addr_router i_addr_router (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .tile_id_i           (tile_id_i),
    .core_req_i          (core_req_i),
    .core_req_valid_i    (core_req_valid_i),
    .core_req_ready_o    (core_req_ready_o),
    .core_resp_o         (core_resp_o),
    .core_resp_valid_o   (core_resp_valid_o),
    .remote_req_o        (remote_req_o),
    .remote_req_valid_o  (remote_req_valid_o),
    .remote_req_ready_i  (remote_req_ready_i),
    .remote_resp_i       (remote_resp_i),
    .remote_resp_valid_i (remote_resp_valid_i),
    .local_req_o         (local_req),
    .local_req_valid_o   (local_req_valid),
    .local_req_ready_i   (local_req_ready),
    .local_resp_i        (local_resp),
    .local_resp_valid_i  (local_resp_valid)
  );

  // Slave address splits into word and bank, the xbar fills in the tag
  for (genvar s = 0; s < `TILE_NUM_CORES; s++) begin : gen_slave_req
    assign slave_bank_req[s] = '{
      word:  slave_req_i[s].addr[`TILE_BANK_W +: `TILE_WORD_W],
      bank:  slave_req_i[s].addr[0 +: `TILE_BANK_W],
      wen:   slave_req_i[s].wen,
      wdata: slave_req_i[s].wdata,
      be:    slave_req_i[s].be,
      ini:   '0
    };
  end

  // Initiator order: core 0, core 1, slave 0, slave 1
  assign ini_req       = {slave_bank_req, local_req};
  assign ini_req_valid = {slave_req_valid_i, local_req_valid};
  assign {slave_req_ready_o, local_req_ready}   = ini_req_ready;
  assign {slave_resp_o, local_resp}             = ini_resp;
  assign {slave_resp_valid_o, local_resp_valid} = ini_resp_valid;

  bank_xbar i_bank_xbar (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .ini_req_i         (ini_req),
    .ini_req_valid_i   (ini_req_valid),
    .ini_req_ready_o   (ini_req_ready),
    .ini_resp_o        (ini_resp),
    .ini_resp_valid_o  (ini_resp_valid),
    .bank_req_o        (bank_req),
    .bank_req_valid_o  (bank_req_valid),
    .bank_resp_i       (bank_resp),
    .bank_resp_valid_i (bank_resp_valid)
  );

  for (genvar b = 0; b < `TILE_NUM_BANKS; b++) begin : gen_banks
    tcdm_bank i_bank (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .req_i        (bank_req[b]),
      .req_valid_i  (bank_req_valid[b]),
      .resp_o       (bank_resp[b]),
      .resp_valid_o (bank_resp_valid[b])
    );
  end

endmodule

/* router/addr_router.sv */
`timescale 1ns/100ps
`include "tile_consts.svh"

module addr_router (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic [`TILE_TILE_W-1:0]                    tile_id_i,
  input  tile_pkg::tcdm_req_t  [`TILE_NUM_CORES-1:0] core_req_i,
  input  logic                 [`TILE_NUM_CORES-1:0] core_req_valid_i,
  output logic                 [`TILE_NUM_CORES-1:0] core_req_ready_o,
  output tile_pkg::tcdm_resp_t [`TILE_NUM_CORES-1:0] core_resp_o,
  output logic                 [`TILE_NUM_CORES-1:0] core_resp_valid_o,
  output tile_pkg::tcdm_req_t                        remote_req_o,
  output logic                                       remote_req_valid_o,
  input  logic                                       remote_req_ready_i,
  input  tile_pkg::tcdm_resp_t                       remote_resp_i,
  input  logic                                       remote_resp_valid_i,
  output tile_pkg::bank_req_t  [`TILE_NUM_CORES-1:0] local_req_o,
  output logic                 [`TILE_NUM_CORES-1:0] local_req_valid_o,
  input  logic                 [`TILE_NUM_CORES-1:0] local_req_ready_i,
  input  tile_pkg::tcdm_resp_t [`TILE_NUM_CORES-1:0] local_resp_i,
  input  logic                 [`TILE_NUM_CORES-1:0] local_resp_valid_i
);

  localparam int unsigned core_idx_w = $clog2(`TILE_NUM_CORES);

  logic                                      ready_en_q;
  logic                 [`TILE_NUM_CORES-1:0] outstanding_q;
  logic                 [`TILE_NUM_CORES-1:0] err_resp_q;
  logic                                      remote_busy_q;
  logic                                      remote_hold_q;
  logic                 [core_idx_w-1:0]     remote_owner_q;

  logic                 [`TILE_NUM_CORES-1:0] req_active;
  logic                 [`TILE_NUM_CORES-1:0] route_err;
  logic                 [`TILE_NUM_CORES-1:0] accept;
  logic                 [`TILE_NUM_CORES-1:0] remote_cand;
  logic                 [`TILE_NUM_CORES-1:0] remote_gnt;
  tile_pkg::tcdm_req_t  [`TILE_NUM_CORES-1:0] remote_req;
  logic                 [core_idx_w-1:0]     remote_sel;
  logic                                      remote_found;

  for (genvar c = 0; c < `TILE_NUM_CORES; c++) begin : gen_core
    logic [`TILE_ADDR_W-1:0] offset;
    tile_pkg::route_e        route;
    logic                    path_ready;
    logic                    remote_hit;

    // Region relative address keeps the field layout
    assign offset = core_req_i[c].addr - `TILE_TCDM_BASE;

    always_comb begin
      if (offset >= `TILE_TCDM_SIZE) begin
        route = tile_pkg::ROUTE_ERROR;
      end else if (offset[`TILE_TILE_LSB +: `TILE_TILE_W] == tile_id_i) begin
        route = tile_pkg::ROUTE_LOCAL;
      end else begin
        route = tile_pkg::ROUTE_REMOTE;
      end
    end

    assign req_active[c]  = ready_en_q && core_req_valid_i[c] && !outstanding_q[c];
    assign route_err[c]   = route == tile_pkg::ROUTE_ERROR;
    assign remote_cand[c] = req_active[c] && route == tile_pkg::ROUTE_REMOTE;
    assign remote_gnt[c]  = !remote_busy_q && remote_found && remote_cand[c] &&
                            remote_sel == core_idx_w'(c);

    assign local_req_valid_o[c] = req_active[c] && route == tile_pkg::ROUTE_LOCAL;
    assign local_req_o[c] = '{
      word:  offset[`TILE_WORD_LSB +: `TILE_WORD_W],
      bank:  offset[`TILE_BANK_LSB +: `TILE_BANK_W],
      wen:   core_req_i[c].wen,
      wdata: core_req_i[c].wdata,
      be:    core_req_i[c].be,
      ini:   '0
    };

    // Tile and bank swap places so the outer network routes on the low bits
    assign remote_req[c] = '{
      addr:  `TILE_ADDR_W'({offset[`TILE_WORD_LSB +: `TILE_WORD_W],
                            offset[`TILE_BANK_LSB +: `TILE_BANK_W],
                            offset[`TILE_TILE_LSB +: `TILE_TILE_W],
                            core_idx_w'(c),
                            offset[0 +: `TILE_BYTE_OFF]}),
      wen:   core_req_i[c].wen,
      wdata: core_req_i[c].wdata,
      be:    core_req_i[c].be
    };

    always_comb begin
      case (route)
        tile_pkg::ROUTE_LOCAL:  path_ready = local_req_ready_i[c];
        tile_pkg::ROUTE_REMOTE: path_ready = remote_gnt[c] && remote_req_ready_i;
        default:                path_ready = 1'b1;
      endcase
    end

    assign core_req_ready_o[c] = ready_en_q && !outstanding_q[c] &&
                                 (!core_req_valid_i[c] || path_ready);
    assign accept[c] = core_req_valid_i[c] && core_req_ready_o[c];

    // At most one of the three sources answers a core in a cycle
    assign remote_hit = remote_busy_q && remote_resp_valid_i &&
                        remote_owner_q == core_idx_w'(c);
    assign core_resp_valid_o[c] = err_resp_q[c] || local_resp_valid_i[c] || remote_hit;
    assign core_resp_o[c] = err_resp_q[c] ? tile_pkg::tcdm_resp_t'{rdata: '0, err: 1'b1} :
                            local_resp_valid_i[c] ? local_resp_i[c] : remote_resp_i;
  end

  // Fixed priority, but a stalled request keeps the port until taken
  always_comb begin
    remote_sel   = remote_owner_q;
    remote_found = remote_hold_q;
    for (int c = 0; c < `TILE_NUM_CORES; c++) begin
      if (!remote_found && remote_cand[c]) begin
        remote_sel   = core_idx_w'(c);
        remote_found = 1'b1;
      end
    end
  end

  assign remote_req_valid_o = |remote_gnt;
  assign remote_req_o       = remote_req[remote_sel];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ready_en_q     <= 1'b0;
      outstanding_q  <= '0;
      err_resp_q     <= '0;
      remote_busy_q  <= 1'b0;
      remote_hold_q  <= 1'b0;
      remote_owner_q <= '0;
    end else begin
      ready_en_q    <= 1'b1;
      outstanding_q <= (outstanding_q & ~core_resp_valid_o) | accept;
      err_resp_q    <= accept & route_err;
      remote_hold_q <= remote_req_valid_o && !remote_req_ready_i;
      if (remote_req_valid_o) begin
        remote_owner_q <= remote_sel;
        remote_busy_q  <= remote_req_ready_i;
      end else if (remote_resp_valid_i) begin
        remote_busy_q <= 1'b0;
      end
    end
  end

endmodule

/* xbar/bank_xbar.sv */
`timescale 1ns/100ps
`include "tile_consts.svh"

module bank_xbar (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  tile_pkg::bank_req_t  [`TILE_NUM_INI-1:0]   ini_req_i,
  input  logic                 [`TILE_NUM_INI-1:0]   ini_req_valid_i,
  output logic                 [`TILE_NUM_INI-1:0]   ini_req_ready_o,
  output tile_pkg::tcdm_resp_t [`TILE_NUM_INI-1:0]   ini_resp_o,
  output logic                 [`TILE_NUM_INI-1:0]   ini_resp_valid_o,
  output tile_pkg::bank_req_t  [`TILE_NUM_BANKS-1:0] bank_req_o,
  output logic                 [`TILE_NUM_BANKS-1:0] bank_req_valid_o,
  input  tile_pkg::bank_resp_t [`TILE_NUM_BANKS-1:0] bank_resp_i,
  input  logic                 [`TILE_NUM_BANKS-1:0] bank_resp_valid_i
);

  logic [`TILE_NUM_BANKS-1:0][`TILE_NUM_INI-1:0] bank_hit;
  logic [`TILE_NUM_BANKS-1:0][`TILE_INI_W-1:0]   rr_q;
  logic [`TILE_NUM_BANKS-1:0][`TILE_INI_W-1:0]   gnt_idx;
  logic [`TILE_NUM_BANKS-1:0]                    gnt_valid;

  for (genvar b = 0; b < `TILE_NUM_BANKS; b++) begin : gen_bank_arb
    logic [`TILE_INI_W-1:0] sel_idx;
    logic                   sel_valid;

    for (genvar i = 0; i < `TILE_NUM_INI; i++) begin : gen_hit
      assign bank_hit[b][i] = ini_req_valid_i[i] && ini_req_i[i].bank == `TILE_BANK_W'(b);
    end

    // Search starts at the initiator after the last winner
    always_comb begin
      logic [`TILE_INI_W-1:0] idx;
      sel_idx   = '0;
      sel_valid = 1'b0;
      for (int k = 0; k < `TILE_NUM_INI; k++) begin
        idx = rr_q[b] + `TILE_INI_W'(k);
        if (!sel_valid && bank_hit[b][idx]) begin
          sel_idx   = idx;
          sel_valid = 1'b1;
        end
      end
    end

    assign gnt_idx[b]   = sel_idx;
    assign gnt_valid[b] = sel_valid;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else begin
      for (int b = 0; b < `TILE_NUM_BANKS; b++) begin
        if (gnt_valid[b]) begin
          rr_q[b] <= gnt_idx[b] + `TILE_INI_W'(1);
        end
      end
    end
  end

  // Winner goes to the bank with its index as tag, losers see ready low
  always_comb begin
    ini_req_ready_o = '0;
    for (int b = 0; b < `TILE_NUM_BANKS; b++) begin
      bank_req_o[b]       = ini_req_i[gnt_idx[b]];
      bank_req_o[b].ini   = gnt_idx[b];
      bank_req_valid_o[b] = gnt_valid[b];
      if (gnt_valid[b]) begin
        ini_req_ready_o[gnt_idx[b]] = 1'b1;
      end
    end
  end

  // Each initiator holds at most one grant, so tags never collide
  always_comb begin
    ini_resp_o       = '0;
    ini_resp_valid_o = '0;
    for (int b = 0; b < `TILE_NUM_BANKS; b++) begin
      if (bank_resp_valid_i[b]) begin
        ini_resp_valid_o[bank_resp_i[b].ini] = 1'b1;
        ini_resp_o[bank_resp_i[b].ini].rdata = bank_resp_i[b].rdata;
      end
    end
  end

endmodule

/* bank/tcdm_bank.sv */
`timescale 1ns/100ps
`include "tile_consts.svh"

module tcdm_bank (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  tile_pkg::bank_req_t  req_i,
  input  logic                 req_valid_i,
  output tile_pkg::bank_resp_t resp_o,
  output logic                 resp_valid_o
);

  logic [`TILE_DATA_W-1:0] mem_q [`TILE_BANK_WORDS];
  logic [`TILE_DATA_W-1:0] rdata_q;
  logic [`TILE_INI_W-1:0]  ini_q;
  logic                    resp_valid_q;

  // Byte masked write
  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_i.wen) begin
      for (int i = 0; i < `TILE_BE_W; i++) begin
        if (req_i.be[i]) begin
          mem_q[req_i.word][8*i +: 8] <= req_i.wdata[8*i +: 8];
        end
      end
    end
  end

  // Writes are acknowledged with zero data
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      rdata_q <= req_i.wen ? '0 : mem_q[req_i.word];
      ini_q   <= req_i.ini;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= req_valid_i;
    end
  end

  assign resp_o       = '{rdata: rdata_q, ini: ini_q};
  assign resp_valid_o = resp_valid_q;

endmodule

/* common/tile_pkg.sv */
`include "tile_consts.svh"

package tile_pkg;

  // Core side request with full byte address
  typedef struct packed {
    logic [`TILE_ADDR_W-1:0] addr;
    logic                    wen;
    logic [`TILE_DATA_W-1:0] wdata;
    logic [`TILE_BE_W-1:0]   be;
  } tcdm_req_t;

  typedef struct packed {
    logic [`TILE_DATA_W-1:0] rdata;
    logic                    err;
  } tcdm_resp_t;

  // Request as seen by the crossbar and the banks
  typedef struct packed {
    logic [`TILE_WORD_W-1:0] word;
    logic [`TILE_BANK_W-1:0] bank;
    logic                    wen;
    logic [`TILE_DATA_W-1:0] wdata;
    logic [`TILE_BE_W-1:0]   be;
    logic [`TILE_INI_W-1:0]  ini;
  } bank_req_t;

  // Bank answer, tagged with the initiator it belongs to
  typedef struct packed {
    logic [`TILE_DATA_W-1:0] rdata;
    logic [`TILE_INI_W-1:0]  ini;
  } bank_resp_t;

  // Incoming request from another tile, address is {word, bank}
  typedef struct packed {
    logic [`TILE_SLAVE_ADDR_W-1:0] addr;
    logic                          wen;
    logic [`TILE_DATA_W-1:0]       wdata;
    logic [`TILE_BE_W-1:0]         be;
  } slave_req_t;

  typedef enum logic [1:0] {
    ROUTE_LOCAL,
    ROUTE_REMOTE,
    ROUTE_ERROR
  } route_e;

endpackage

/* common/tile_consts.svh */
`ifndef TILE_CONSTS_SVH
`define TILE_CONSTS_SVH

// Cluster geometry
`define TILE_NUM_CORES    2
`define TILE_NUM_BANKS    4
`define TILE_NUM_TILES    4
`define TILE_BANK_WORDS   256

// Crossbar initiators: cores first, then slave ports
`define TILE_NUM_INI      (2 * `TILE_NUM_CORES)
`define TILE_INI_W        2

// Data path
`define TILE_DATA_W       32
`define TILE_BE_W         4
`define TILE_ADDR_W       32

// Address fields, low to high: byte, bank, tile, word
`define TILE_BYTE_OFF     2
`define TILE_BANK_W       2
`define TILE_TILE_W       2
`define TILE_WORD_W       8
`define TILE_BANK_LSB     `TILE_BYTE_OFF
`define TILE_TILE_LSB     (`TILE_BANK_LSB + `TILE_BANK_W)
`define TILE_WORD_LSB     (`TILE_TILE_LSB + `TILE_TILE_W)
`define TILE_SLAVE_ADDR_W (`TILE_WORD_W + `TILE_BANK_W)

// Shared memory region, 16 KiB
`define TILE_TCDM_BASE    32'h0001_0000
`define TILE_TCDM_SIZE    (`TILE_NUM_TILES * `TILE_NUM_BANKS * `TILE_BANK_WORDS * `TILE_BE_W)

`endif
